//--- build.f
+incdir+.
bus_pkg.sv
io_pkg.sv
mem_bus_if.sv
mem_arbiter.sv
onchip_ram.sv
io_regs.sv
soc_bus_top.sv
tb_soc_bus.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_soc_bus
FILELIST   := build.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_TEXT  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_soc_bus_table.svh
`ifndef TB_SOC_BUS_TABLE_SVH
`define TB_SOC_BUS_TABLE_SVH

// each row holds the test, instr bus, io flag, write flag, byte address, write data,
// bytesel and read data. the read data column is only checked on reads.
typedef struct packed {
    logic [2:0]  test;
    logic        instr;
    logic        io;
    logic        wr;
    logic [19:0] addr;
    word_t       wdata;
    bytesel_t    bytesel;
    word_t       exp;
} row_t;

localparam int table_rows = 25;

row_t stim_table [table_rows];

task automatic fill_table();
    stim_table[0]  = '{3'd2, 1'b0, 1'b0, 1'b0, 20'h00000, 16'h0000, 2'b11, 16'h0000};
    stim_table[1]  = '{3'd2, 1'b0, 1'b0, 1'b0, 20'h00400, 16'h0000, 2'b11, 16'h0000};
    stim_table[2]  = '{3'd2, 1'b0, 1'b0, 1'b0, 20'h007fe, 16'h0000, 2'b11, 16'h0000};
    stim_table[3]  = '{3'd3, 1'b0, 1'b0, 1'b1, 20'h00100, 16'h1234, 2'b11, 16'h0000};
    stim_table[4]  = '{3'd3, 1'b0, 1'b0, 1'b1, 20'h00100, 16'habcd, 2'b01, 16'h0000};
    stim_table[5]  = '{3'd3, 1'b0, 1'b0, 1'b1, 20'h00100, 16'h5a77, 2'b10, 16'h0000};
    stim_table[6]  = '{3'd3, 1'b0, 1'b0, 1'b0, 20'h00100, 16'h0000, 2'b11, 16'h5acd};
    stim_table[7]  = '{3'd3, 1'b0, 1'b0, 1'b1, 20'h00902, 16'hbeef, 2'b11, 16'h0000};
    stim_table[8]  = '{3'd3, 1'b0, 1'b0, 1'b0, 20'h00102, 16'h0000, 2'b11, 16'hbeef};
    stim_table[9]  = '{3'd3, 1'b0, 1'b0, 1'b0, 20'h40902, 16'h0000, 2'b11, 16'hbeef};
    stim_table[10] = '{3'd4, 1'b1, 1'b0, 1'b0, 20'h00100, 16'h0000, 2'b11, 16'h5acd};
    stim_table[11] = '{3'd4, 1'b1, 1'b0, 1'b0, 20'h00102, 16'h0000, 2'b11, 16'hbeef};
    stim_table[12] = '{3'd4, 1'b0, 1'b0, 1'b1, 20'h00104, 16'hc0de, 2'b11, 16'h0000};
    stim_table[13] = '{3'd4, 1'b1, 1'b0, 1'b0, 20'h00104, 16'h0000, 2'b11, 16'hc0de};
    stim_table[14] = '{3'd6, 1'b0, 1'b1, 1'b1, 20'h0fffe, 16'h00a5, 2'b01, 16'h0000};
    stim_table[15] = '{3'd6, 1'b0, 1'b1, 1'b0, 20'h0fffe, 16'h0000, 2'b11, 16'h00a5};
    stim_table[16] = '{3'd6, 1'b0, 1'b1, 1'b1, 20'h0fffe, 16'h3c5a, 2'b10, 16'h0000};
    stim_table[17] = '{3'd6, 1'b0, 1'b1, 1'b0, 20'h0fffe, 16'h0000, 2'b11, 16'h00a5};
    stim_table[18] = '{3'd6, 1'b0, 1'b1, 1'b0, 20'h0fffc, 16'h0000, 2'b11, 16'h0001};
    stim_table[19] = '{3'd6, 1'b0, 1'b1, 1'b1, 20'h0fffc, 16'hffff, 2'b11, 16'h0000};
    stim_table[20] = '{3'd6, 1'b0, 1'b1, 1'b0, 20'h0fffc, 16'h0000, 2'b11, 16'h0001};
    stim_table[21] = '{3'd6, 1'b0, 1'b1, 1'b1, 20'h00100, 16'hffff, 2'b11, 16'h0000};
    stim_table[22] = '{3'd6, 1'b0, 1'b1, 1'b0, 20'h00100, 16'h0000, 2'b11, 16'h0000};
    stim_table[23] = '{3'd6, 1'b0, 1'b0, 1'b0, 20'h00100, 16'h0000, 2'b11, 16'h5acd};
    stim_table[24] = '{3'd6, 1'b0, 1'b0, 1'b0, 20'h007fe, 16'h0000, 2'b11, 16'h0000};
endtask

`endif

//--- tb_soc_bus.sv
`timescale 1ns/1ps

module tb_soc_bus
    import bus_pkg::*;
();

    localparam int mem_addr_bits = 10;
    localparam int ack_limit = 64;
    localparam logic [19:0] status_byte_addr = 20'h0fffc;
    localparam logic [14:0] leds_word_port = 15'h7fff; // byte address 0xfffe.
    localparam logic [15:0] lfsr_seed = 16'd67;

    `include "tb_soc_bus_table.svh"

    // each row may use its full ack limit, and the clear takes one cycle per ram word.
    localparam int watchdog_cycles = table_rows * ack_limit + (1 << mem_addr_bits) + 1024;

    logic       clk;
    logic       reset;
    addr_t      instr_addr;
    logic       instr_access;
    logic       instr_ack;
    word_t      instr_rdata;
    addr_t      data_addr;
    word_t      data_wdata;
    word_t      data_rdata;
    logic       data_access;
    logic       data_ack;
    logic       data_wr_en;
    bytesel_t   data_bytesel;
    logic       data_io;
    logic [7:0] leds;

    word_t      model [1 << mem_addr_bits];
    logic [7:0] leds_model;
    int         errors;
    int         checks;
    int         test_start;

    soc_bus_top #(
        .mem_addr_bits (mem_addr_bits)
    ) u_soc_bus_top (
        .clk          (clk),
        .reset        (reset),
        .instr_addr   (instr_addr),
        .instr_access (instr_access),
        .instr_ack    (instr_ack),
        .instr_rdata  (instr_rdata),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_access  (data_access),
        .data_ack     (data_ack),
        .data_wr_en   (data_wr_en),
        .data_bytesel (data_bytesel),
        .data_io      (data_io),
        .leds         (leds)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input bytesel_t sel);
        word_t w;
        w = old_word;
        if (sel[0]) w[7:0] = new_word[7:0];
        if (sel[1]) w[15:8] = new_word[15:8];
        return w;
    endfunction

    // the ram only sees the low address bits.
    function automatic logic [mem_addr_bits-1:0] model_index(input addr_t a);
        return a[mem_addr_bits:1];
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1: return "reset values";
            2: return "clear then ready";
            3: return "byte enabled writes";
            4: return "shared memory";
            5: return "contention";
            default: return "i/o ports";
        endcase
    endfunction

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERR %s: got 0x%04h, expected 0x%04h", name, actual, expected);
        end
    endtask

    task automatic report_test(input int id);
        if (errors == test_start) $display("test %0d %s: ok", id, test_name(id));
        else $display("test %0d %s: %0d errors", id, test_name(id), errors - test_start);
        test_start = errors;
    endtask

    task automatic run_data(input logic io, input logic wr, input addr_t addr,
                            input word_t wdata, input bytesel_t sel,
                            output word_t rdata, output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        rdata = '0;
        @(posedge clk);
        #1;
        data_io = io;
        data_wr_en = wr;
        data_addr = addr;
        data_wdata = wdata;
        data_bytesel = sel;
        data_access = 1'b1;
        while (!ok && cycles < ack_limit) begin
            @(negedge clk);
            if (data_ack) begin
                ok = 1'b1;
                rdata = data_rdata;
            end
            cycles++;
        end
        @(posedge clk);
        #1 data_access = 1'b0;
        if (!ok) begin
            errors++;
            $display("no ack within limit on the data bus, word address 0x%05h", addr);
        end
    endtask

    task automatic run_instr(input addr_t addr, output word_t rdata, output logic ok);
        int cycles;
        cycles = 0;
        ok = 1'b0;
        rdata = '0;
        @(posedge clk);
        #1;
        instr_addr = addr;
        instr_access = 1'b1;
        while (!ok && cycles < ack_limit) begin
            @(negedge clk);
            if (instr_ack) begin
                ok = 1'b1;
                rdata = instr_rdata;
            end
            cycles++;
        end
        @(posedge clk);
        #1 instr_access = 1'b0;
        if (!ok) begin
            errors++;
            $display("no ack within limit on the instruction bus, word address 0x%05h", addr);
        end
    endtask

    task automatic test_reset();
        word_t rd;
        logic  ok;
        test_start = errors;
        @(negedge clk);
        check_value("leds", word_t'(leds), 16'h0000);
        check_value("instr_ack", word_t'(instr_ack), 16'h0000);
        check_value("data_ack", word_t'(data_ack), 16'h0000);
        run_data(1'b1, 1'b0, status_byte_addr[19:1], '0, 2'b11, rd, ok);
        if (ok) check_value("data_rdata", rd, 16'h0000); // the clear is still running.
        report_test(1);
    endtask

    task automatic poll_ready();
        word_t rd;
        logic  ok;
        logic  ready_seen;
        int    polls;
        test_start = errors;
        ready_seen = 1'b0;
        polls = 0;
        while (!ready_seen && polls < (1 << mem_addr_bits)) begin
            run_data(1'b1, 1'b0, status_byte_addr[19:1], '0, 2'b11, rd, ok);
            if (!ok) break;
            ready_seen = rd[0];
            polls++;
        end
        if (!ready_seen) begin
            errors++;
            $display("the ram clear never finished, status bit 0 stayed low");
        end
    endtask

    task automatic apply_row(input row_t row);
        word_t rd;
        logic  ok;
        addr_t a;
        a = row.addr[19:1];
        if (row.instr) run_instr(a, rd, ok);
        else run_data(row.io, row.wr, a, row.wdata, row.bytesel, rd, ok);
        if (ok) begin
            if (!row.wr) check_value(row.instr ? "instr_rdata" : "data_rdata", rd, row.exp);
            if (row.instr) check_value("instr_rdata", rd, model[model_index(a)]);
            if (!row.io && row.wr) begin
                model[model_index(a)] = merge_bytes(model[model_index(a)], row.wdata, row.bytesel);
            end
            if (row.io && row.wr && a[15:1] == leds_word_port && row.bytesel[0]) begin
                leds_model = row.wdata[7:0];
            end
            if (row.io) check_value("leds", word_t'(leds), word_t'(leds_model));
        end
    endtask

    // test 2 begins with the status poll, so its report waits for the first test 3 row.
    task automatic run_table();
        int cur;
        cur = 2;
        for (int i = 0; i < table_rows; i++) begin
            if (int'(stim_table[i].test) != cur) begin
                report_test(cur);
                cur = int'(stim_table[i].test);
            end
            apply_row(stim_table[i]);
        end
        report_test(cur);
    endtask

    task automatic test_contention();
        logic [15:0] lfsr;
        word_t       wdata;
        word_t       old_word;
        word_t       rd;
        word_t       ird;
        word_t       drd;
        logic        ok;
        logic        iok;
        logic        dok;
        addr_t       a;
        test_start = errors;
        a = addr_t'(20'h00200 >> 1);
        lfsr = lfsr_seed;
        wdata = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_step(lfsr);
            wdata = {wdata[14:0], lfsr[0]};
        end
        // a data transfer right before gives the waiting fetch the next turn.
        run_data(1'b0, 1'b0, a, '0, 2'b11, rd, ok);
        if (ok) check_value("data_rdata", rd, model[model_index(a)]);
        old_word = model[model_index(a)];
        fork
            run_data(1'b0, 1'b1, a, wdata, 2'b11, drd, dok);
            run_instr(a, ird, iok);
        join
        if (iok) check_value("instr_rdata", ird, old_word);
        if (dok) check_value("data_rdata", drd, old_word); // a write ack returns the old word.
        if (dok) model[model_index(a)] = merge_bytes(old_word, wdata, 2'b11);
        run_data(1'b0, 1'b0, a, '0, 2'b11, rd, ok);
        if (ok) check_value("data_rdata", rd, model[model_index(a)]);
        report_test(5);
    endtask

    initial begin
        reset = 1'b1;
        instr_addr = '0;
        instr_access = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_access = 1'b0;
        data_wr_en = 1'b0;
        data_bytesel = '0;
        data_io = 1'b0;
        errors = 0;
        checks = 0;
        test_start = 0;
        leds_model = '0;
        foreach (model[i]) model[i] = '0;
        fill_table();
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        test_reset();
        poll_ready();
        run_table();
        test_contention();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top
    import bus_pkg::*;
#(
    parameter int mem_addr_bits = 10
) (
    input  logic       clk,
    input  logic       reset,

    // the instruction host only reads.
    input  addr_t      instr_addr,
    input  logic       instr_access,
    output logic       instr_ack,
    output word_t      instr_rdata,

    // data_io steers a data host access to the i/o register block.
    input  addr_t      data_addr,
    input  word_t      data_wdata,
    output word_t      data_rdata,
    input  logic       data_access,
    output logic       data_ack,
    input  logic       data_wr_en,
    input  bytesel_t   data_bytesel,
    input  logic       data_io,

    output logic [7:0] leds
);

    logic mem_ready;

    mem_bus_if q_bus ();
    mem_bus_if io_bus ();

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .reset        (reset),
        .instr_addr   (instr_addr),
        .instr_access (instr_access),
        .instr_ack    (instr_ack),
        .instr_rdata  (instr_rdata),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_access  (data_access),
        .data_wr_en   (data_wr_en),
        .data_bytesel (data_bytesel),
        .data_io      (data_io),
        .data_ack     (data_ack),
        .data_rdata   (data_rdata),
        .q_bus        (q_bus),
        .io_bus       (io_bus)
    );

    onchip_ram #(
        .mem_addr_bits (mem_addr_bits)
    ) u_onchip_ram (
        .clk   (clk),
        .reset (reset),
        .mem   (q_bus),
        .ready (mem_ready)
    );

    // the status port shows software when the ram clear has finished.
    io_regs u_io_regs (
        .clk       (clk),
        .reset     (reset),
        .io        (io_bus),
        .mem_ready (mem_ready),
        .leds      (leds)
    );

endmodule

//--- io_regs.sv
`timescale 1ns/1ps

module io_regs
    import bus_pkg::*, io_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    mem_bus_if.target        io,
    input  logic             mem_ready,
    output logic [7:0]       leds
);

    io_port_t port;
    logic     take;
    logic     leds_write;

    assign port = io.addr[io_port_bits:addr_lsb];

    // no new access is taken in the cycle of an ack because the host drops access then.
    assign take = io.access & ~io.ack;

    // only the low byte lane reaches the leds.
    assign leds_write = take & io.wr_en & io.bytesel[0] & (port == leds_port);

    always_ff @(posedge clk) begin
        if (reset) begin
            io.ack <= 1'b0;
            leds   <= '0;
        end else begin
            io.ack <= take;
            if (leds_write) begin
                leds <= io.wdata[7:0];
            end
        end
    end

    // unmapped ports still answer so that a stray access cannot hang the host.
    always_ff @(posedge clk) begin
        if (take) begin
            case (port)
                leds_port:       io.rdata <= word_t'(leds);
                mem_status_port: io.rdata <= word_t'(mem_ready);
                default:         io.rdata <= '0;
            endcase
        end
    end

    single_ack: assert property (@(posedge clk) disable iff (reset)
        io.ack |=> !io.ack);

endmodule

//--- onchip_ram.sv
`timescale 1ns/1ps

module onchip_ram
    import bus_pkg::*;
#(
    parameter int mem_addr_bits = 10
) (
    input  logic       clk,
    input  logic       reset,
    mem_bus_if.target  mem,
    output logic       ready
);

    localparam int mem_words = 1 << mem_addr_bits;

    typedef logic [mem_addr_bits-1:0] ram_idx_t;

    word_t    ram [mem_words];
    ram_idx_t clear_idx;
    ram_idx_t idx;
    logic     take;

    // upper address bits are ignored, so memory aliases above the ram size.
    assign idx = mem.addr[mem_addr_bits:addr_lsb];

    // an access is taken once, in the cycle before its ack.
    assign take = mem.access & ready & ~mem.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            clear_idx <= '0;
            ready     <= 1'b0;
            mem.ack   <= 1'b0;
        end else begin
            mem.ack <= take;
            if (!ready) begin
                clear_idx <= clear_idx + 1'b1;
                if (&clear_idx) begin
                    ready <= 1'b1; // the last word is written in this cycle.
                end
            end
        end
    end

    // the clear sequencer owns the write port until ready rises.
    always_ff @(posedge clk) begin
        if (!ready) begin
            ram[clear_idx] <= '0;
        end else if (take && mem.wr_en) begin
            if (mem.bytesel[0]) begin
                ram[idx][byte_bits-1:0] <= mem.wdata[byte_bits-1:0];
            end
            if (mem.bytesel[1]) begin
                ram[idx][word_bits-1:byte_bits] <= mem.wdata[word_bits-1:byte_bits];
            end
        end
    end

    // read happens before the write lands, so a write ack returns the old word.
    always_ff @(posedge clk) begin
        if (take) begin
            mem.rdata <= ram[idx];
        end
    end

    ack_after_access: assert property (@(posedge clk) disable iff (reset)
        mem.ack |-> $past(mem.access));

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import bus_pkg::*, io_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  addr_t      instr_addr,
    input  logic       instr_access,
    output logic       instr_ack,
    output word_t      instr_rdata,

    input  addr_t      data_addr,
    input  word_t      data_wdata,
    input  logic       data_access,
    input  logic       data_wr_en,
    input  bytesel_t   data_bytesel,
    input  logic       data_io,
    output logic       data_ack,
    output word_t      data_rdata,

    mem_bus_if.host    q_bus,
    mem_bus_if.host    io_bus
);

    arb_state_t state;
    logic       last_data; // set while the last memory transfer went to the data host.
    logic       data_mem_req;
    logic       grant_instr;
    logic       grant_data;
    logic       instr_mem_ack;
    logic       data_mem_ack;

    assign data_mem_req = data_access & ~data_io;

    // a waiting instruction fetch goes first once data has had its turn.
    assign grant_instr = (state == idle) & instr_access & (last_data | ~data_mem_req);
    assign grant_data  = (state == idle) & data_mem_req & ~grant_instr;

    assign instr_mem_ack = (state == instr_mem) & q_bus.ack;
    assign data_mem_ack  = (state == data_mem) & q_bus.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            q_bus.access <= 1'b0;
            last_data    <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (grant_instr) begin
                        state        <= instr_mem;
                        q_bus.access <= 1'b1;
                    end else if (grant_data) begin
                        state        <= data_mem;
                        q_bus.access <= 1'b1;
                    end
                end
                data_mem, instr_mem: begin
                    if (q_bus.ack) begin
                        state        <= idle;
                        q_bus.access <= 1'b0;
                        last_data    <= (state == data_mem);
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // request fields are captured with the grant and held for the whole transfer.
    always_ff @(posedge clk) begin
        if (grant_instr) begin
            q_bus.addr    <= instr_addr;
            q_bus.wdata   <= '0;
            q_bus.wr_en   <= 1'b0;
            q_bus.bytesel <= bytesel_word;
        end else if (grant_data) begin
            q_bus.addr    <= data_addr;
            q_bus.wdata   <= data_wdata;
            q_bus.wr_en   <= data_wr_en;
            q_bus.bytesel <= data_bytesel;
        end
    end

    // i/o accesses bypass the arbiter and reach the register block directly.
    assign io_bus.access  = data_access & data_io;
    assign io_bus.addr    = data_addr;
    assign io_bus.wdata   = data_wdata;
    assign io_bus.wr_en   = data_wr_en;
    assign io_bus.bytesel = data_bytesel;

    assign instr_ack   = instr_mem_ack;
    assign instr_rdata = q_bus.rdata;

    assign data_ack   = data_mem_ack | (data_io & io_bus.ack);
    assign data_rdata = data_io ? io_bus.rdata : q_bus.rdata;

    // each ram ack reaches exactly one host, and that host is still waiting for it.
    one_mem_ack: assert property (@(posedge clk) disable iff (reset)
        q_bus.ack |-> ((instr_mem_ack && instr_access) != (data_mem_ack && data_mem_req)));

    // the ram never answers a bus that the arbiter has not granted.
    ack_when_granted: assert property (@(posedge clk) disable iff (reset)
        q_bus.ack |-> state != idle);

endmodule

//--- mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if
    import bus_pkg::*;
();

    addr_t    addr;
    word_t    wdata;
    word_t    rdata;
    logic     access;
    logic     ack;
    logic     wr_en;
    bytesel_t bytesel;

    // the host holds its request stable until it sees a one cycle ack.
    modport host (
        output addr,
        output wdata,
        output access,
        output wr_en,
        output bytesel,
        input  rdata,
        input  ack
    );

    modport target (
        input  addr,
        input  wdata,
        input  access,
        input  wr_en,
        input  bytesel,
        output rdata,
        output ack
    );

endinterface

//--- io_pkg.sv
package io_pkg;

    // i/o decode looks only at the low 15 bits of the word address.
    localparam int io_port_bits = 15;

    typedef logic [io_port_bits-1:0] io_port_t;

    // byte address 0xfffe.
    localparam io_port_t leds_port = 15'h7fff;

    // bit 0 of the port at byte address 0xfffc reads back the ram clear status.
    localparam io_port_t mem_status_port = 15'h7ffe;

    // which host currently owns the memory bus.
    typedef enum logic [1:0] {
        idle,
        data_mem,
        instr_mem
    } arb_state_t;

endpackage

//--- bus_pkg.sv
package bus_pkg;

    // data words are 16 bits wide and split into two byte lanes.
    localparam int word_bits = 16;
    localparam int byte_bits = 8;
    localparam int byte_lanes = word_bits / byte_bits;

    // hosts address words, so byte address bit 0 never travels on the bus.
    localparam int addr_msb = 19;
    localparam int addr_lsb = 1;

    typedef logic [word_bits-1:0] word_t;

    // bits 19 down to 1 of the byte address.
    typedef logic [addr_msb:addr_lsb] addr_t;

    // bit 0 enables the low byte and bit 1 the high byte.
    typedef logic [byte_lanes-1:0] bytesel_t;

    // an access that touches both lanes.
    localparam bytesel_t bytesel_word = '1;

endpackage
